/* rtl/alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module alu import exec_pkg::*; (
  input  fu_packet_t packet,
  input  logic       cdb_valid,
  input  logic       rollback_en,
  input  rob_idx_t   rollback_idx,
  output fu_result_t result,
  output logic       fu_free
);

  localparam int SHAMT_W = $clog2(`XLEN);

  data_t                opa;
  data_t                opb;
  data_t                alu_out;
  data_t                sign_fill;
  logic [SHAMT_W-1:0]   shamt;
  logic                 squash;

  // signed less-than from sign bits plus unsigned magnitude
  function automatic logic signed_lt(input data_t a, input data_t b);
    if (a[`XLEN-1] == b[`XLEN-1]) begin
      return a < b;
    end
    // signs differ, the negative one is smaller
    return a[`XLEN-1];
  endfunction

  // rollback only hits a packet with the same rob entry
  assign squash = rollback_en && (packet.rob_idx == rollback_idx);

  // free when the bus drains us, nothing is waiting, or the work dies
  assign fu_free = cdb_valid || !packet.ready || squash;

  assign opa = packet.t1_value;

  // literal is zero-extended
  assign opb = (packet.opb_sel == opb_is_imm) ? data_t'(packet.imm) : packet.t2_value;

  assign shamt = opb[SHAMT_W-1:0];

  // upper bits vacated by a logical right shift, filled with the sign
  assign sign_fill = ~({`XLEN{1'b1}} >> shamt) & {`XLEN{opa[`XLEN-1]}};

  always_comb begin
    alu_out = '0;
    case (packet.func)
      alu_addq:   alu_out = opa + opb;
      alu_subq:   alu_out = opa - opb;
      alu_and:    alu_out = opa & opb;
      alu_bic:    alu_out = opa & ~opb;
      alu_bis:    alu_out = opa | opb;
      alu_ornot:  alu_out = opa | ~opb;
      alu_xor:    alu_out = opa ^ opb;
      alu_eqv:    alu_out = opa ^ ~opb;
      alu_srl:    alu_out = opa >> shamt;
      alu_sll:    alu_out = opa << shamt;
      alu_sra:    alu_out = (opa >> shamt) | sign_fill;
      // compares return 0 or 1 in bit 0
      alu_cmpult: alu_out = data_t'(opa < opb);
      alu_cmpeq:  alu_out = data_t'(opa == opb);
      alu_cmpule: alu_out = data_t'(opa <= opb);
      alu_cmplt:  alu_out = data_t'(signed_lt(opa, opb));
      alu_cmple:  alu_out = data_t'(signed_lt(opa, opb) || (opa == opb));
      default:    alu_out = '0;
    endcase
  end

  // tags ride along unchanged
  always_comb begin
    result.done    = packet.ready && !squash;
    result.result  = alu_out;
    result.t_idx   = packet.t_idx;
    result.rob_idx = packet.rob_idx;
  end

endmodule

`default_nettype wire

/* rtl/br_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module br_unit import exec_pkg::*; (
  input  fu_packet_t packet,
  output fu_result_t result,
  output logic       take_branch
);

  data_t      opa;
  data_t      disp_ext;
  logic [2:0] cond;
  logic       opa_zero;
  logic       opa_neg;
  logic       cond_raw;
  logic       cond_holds;

  assign opa  = packet.t1_value;
  assign cond = packet.br_cond;

  assign opa_zero = (opa == '0);
  assign opa_neg  = opa[`XLEN-1];

  // four base tests on the first operand
  always_comb begin
    case (cond[1:0])
      2'b00:   cond_raw = !opa[0];
      2'b01:   cond_raw = opa_zero;
      2'b10:   cond_raw = opa_neg;
      default: cond_raw = opa_neg || opa_zero;
    endcase
  end

  // bit 2 gives lbs, ne, ge and gt
  assign cond_holds = cond_raw ^ cond[2];

  assign take_branch = packet.uncond_branch || (packet.cond_branch && cond_holds);

  // word displacement, sign-extended and scaled to bytes
  assign disp_ext = {{(`XLEN - `BR_DISP_W - 2){packet.br_disp[`BR_DISP_W-1]}},
                     packet.br_disp, 2'b00};

  // branch resolves in the same cycle, no rollback check on itself
  assign result.done    = packet.ready;
  assign result.result  = packet.npc + disp_ext;
  assign result.t_idx   = packet.t_idx;
  assign result.rob_idx = packet.rob_idx;

endmodule

`default_nettype wire

/* rtl/exec_params.svh */
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath word width in bits
`define XLEN 64

// reorder buffer depth
// index width is derived with $clog2 in the package
`define NUM_ROB 16

// physical register file size
// sets the width of the destination tag
`define NUM_PR 32

// multiplier pipeline depth
// each stage eats XLEN/NUM_MULT_STAGE multiplier bits
// so XLEN must divide evenly, 2, 4 and 8 all work for 64 bits
// stages 0 .. NUM_MULT_STAGE-2 hold registers
// the final stage is a combinational adder onto the result
`define NUM_MULT_STAGE 4

// literal field widths inside the issue packet
// immediate is zero-extended, displacement sign-extended and scaled by 4
`define IMM_W 8
`define BR_DISP_W 21

`endif

/* rtl/exec_pkg.sv */
`default_nettype none

`include "exec_params.svh"

package exec_pkg;

  // data word and tag widths
  typedef logic [`XLEN-1:0]             data_t;
  typedef logic [$clog2(`NUM_ROB)-1:0]  rob_idx_t;
  typedef logic [$clog2(`NUM_PR)-1:0]   pr_idx_t;
  typedef logic [`IMM_W-1:0]            imm_t;
  typedef logic [`BR_DISP_W-1:0]        br_disp_t;

  // integer alu operations, all sixteen codes used
  typedef enum logic [3:0] {
    alu_addq   = 4'h0,
    alu_subq   = 4'h1,
    alu_and    = 4'h2,
    alu_bic    = 4'h3,
    alu_bis    = 4'h4,
    alu_ornot  = 4'h5,
    alu_xor    = 4'h6,
    alu_eqv    = 4'h7,
    alu_srl    = 4'h8,
    alu_sll    = 4'h9,
    alu_sra    = 4'ha,
    alu_cmpult = 4'hb,
    alu_cmpeq  = 4'hc,
    alu_cmpule = 4'hd,
    alu_cmplt  = 4'he,
    alu_cmple  = 4'hf
  } alu_func_e;

  // second operand source
  typedef enum logic {
    opb_is_regb = 1'b0,
    opb_is_imm  = 1'b1
  } opb_sel_e;

  // branch conditions on the first operand
  // low two bits pick the test, bit 2 inverts it
  typedef enum logic [2:0] {
    br_lbc = 3'b000,
    br_eq  = 3'b001,
    br_lt  = 3'b010,
    br_le  = 3'b011,
    br_lbs = 3'b100,
    br_ne  = 3'b101,
    br_ge  = 3'b110,
    br_gt  = 3'b111
  } br_cond_e;

  // one issue packet per functional unit
  typedef struct packed {
    logic      ready;
    alu_func_e func;
    opb_sel_e  opb_sel;
    data_t     t1_value;
    data_t     t2_value;
    imm_t      imm;
    br_disp_t  br_disp;
    br_cond_e  br_cond;
    logic      cond_branch;
    logic      uncond_branch;
    data_t     npc;
    pr_idx_t   t_idx;
    rob_idx_t  rob_idx;
  } fu_packet_t;

  // tagged result heading for the common data bus
  typedef struct packed {
    logic     done;
    data_t    result;
    pr_idx_t  t_idx;
    rob_idx_t rob_idx;
  } fu_result_t;

endpackage

`default_nettype wire

/* rtl/exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module exec_unit import exec_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  fu_packet_t alu_packet,
  input  fu_packet_t mult_packet,
  input  fu_packet_t br_packet,
  input  logic       alu_cdb_valid,
  input  logic       mult_cdb_valid,
  input  logic       rollback_en,
  input  rob_idx_t   rollback_idx,
  output fu_result_t alu_result,
  output fu_result_t mult_result,
  output fu_result_t br_result,
  output logic       alu_free,
  output logic       mult_free,
  output logic       take_branch
);

  // single cycle integer unit
  alu u_alu (
    .packet       (alu_packet),
    .cdb_valid    (alu_cdb_valid),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .result       (alu_result),
    .fu_free      (alu_free)
  );

  // pipelined multiplier, low half of the product
  mult u_mult (
    .clock        (clock),
    .rst_n        (rst_n),
    .packet       (mult_packet),
    .cdb_valid    (mult_cdb_valid),
    .rollback_en  (rollback_en),
    .rollback_idx (rollback_idx),
    .result       (mult_result),
    .fu_free      (mult_free)
  );

  // branch condition and target
  // resolves immediately, so it needs no bus grant or free level
  br_unit u_br (
    .packet      (br_packet),
    .result      (br_result),
    .take_branch (take_branch)
  );

endmodule

`default_nettype wire

/* rtl/mult.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module mult import exec_pkg::*; (
  input  logic       clock,
  input  logic       rst_n,
  input  fu_packet_t packet,
  input  logic       cdb_valid,
  input  logic       rollback_en,
  input  rob_idx_t   rollback_idx,
  output fu_result_t result,
  output logic       fu_free
);

  localparam int N    = `NUM_MULT_STAGE;
  localparam int LAST = N - 1;

  data_t    opb;
  data_t    product_in   [N];
  data_t    mplier_in    [N];
  data_t    mcand_in     [N];
  data_t    product_out  [N];
  data_t    mplier_out   [N];
  data_t    mcand_out    [N];
  data_t    next_product [N];
  pr_idx_t  t_idx_in     [N];
  pr_idx_t  t_idx_out    [N];
  rob_idx_t rob_idx_in   [N];
  rob_idx_t rob_idx_out  [N];
  logic     ready_in     [N];
  logic     done         [N];
  logic     advance      [N];
  logic     advance_prev [N];
  logic     out_squash;

  assign opb = (packet.opb_sel == opb_is_imm) ? data_t'(packet.imm) : packet.t2_value;

  for (genvar i = 0; i < N; i++) begin : g_stage
    if (i == 0) begin : g_head
      // issue packet enters with an empty partial product
      assign product_in[i] = '0;
      assign mplier_in[i]  = packet.t1_value;
      assign mcand_in[i]   = opb;
      assign ready_in[i]   = packet.ready;
      assign t_idx_in[i]   = packet.t_idx;
      assign rob_idx_in[i] = packet.rob_idx;
    end else begin : g_body
      assign product_in[i] = product_out[i-1];
      assign mplier_in[i]  = mplier_out[i-1];
      assign mcand_in[i]   = mcand_out[i-1];
      assign ready_in[i]   = done[i-1];
      assign t_idx_in[i]   = t_idx_out[i-1];
      assign rob_idx_in[i] = rob_idx_out[i-1];
    end

    // last stage drains on the bus grant, others follow downstream
    if (i == LAST) begin : g_tail
      assign advance[i] = cdb_valid;
    end else begin : g_link
      assign advance[i] = advance_prev[i+1];
    end

    mult_stage u_stage (
      .clock        (clock),
      .rst_n        (rst_n),
      .advance      (advance[i]),
      .ready_in     (ready_in[i]),
      .product_in   (product_in[i]),
      .mplier_in    (mplier_in[i]),
      .mcand_in     (mcand_in[i]),
      .t_idx        (t_idx_in[i]),
      .rob_idx      (rob_idx_in[i]),
      .rollback_en  (rollback_en),
      .rollback_idx (rollback_idx),
      .done         (done[i]),
      .product_out  (product_out[i]),
      .mplier_out   (mplier_out[i]),
      .mcand_out    (mcand_out[i]),
      .next_product (next_product[i]),
      .t_idx_out    (t_idx_out[i]),
      .rob_idx_out  (rob_idx_out[i]),
      .advance_prev (advance_prev[i])
    );
  end

  // the entry waiting at the output can be rolled back too
  assign out_squash = rollback_en && done[LAST-1] && (rob_idx_out[LAST-1] == rollback_idx);

  // final chunk is summed combinationally onto the bus
  assign result.done    = done[LAST-1] && !out_squash;
  assign result.result  = next_product[LAST];
  assign result.t_idx   = t_idx_out[LAST-1];
  assign result.rob_idx = rob_idx_out[LAST-1];

  assign fu_free = advance_prev[0];

endmodule

`default_nettype wire

/* rtl/mult_stage.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module mult_stage import exec_pkg::*; (
  input  logic     clock,
  input  logic     rst_n,
  input  logic     advance,
  input  logic     ready_in,
  input  data_t    product_in,
  input  data_t    mplier_in,
  input  data_t    mcand_in,
  input  pr_idx_t  t_idx,
  input  rob_idx_t rob_idx,
  input  logic     rollback_en,
  input  rob_idx_t rollback_idx,
  output logic     done,
  output data_t    product_out,
  output data_t    mplier_out,
  output data_t    mcand_out,
  output data_t    next_product,
  output pr_idx_t  t_idx_out,
  output rob_idx_t rob_idx_out,
  output logic     advance_prev
);

  // multiplier bits consumed here
  localparam int CHUNK = `XLEN / `NUM_MULT_STAGE;

  data_t partial;
  logic  squash;

  // incoming entry belongs to the rolled back rob slot
  assign squash = rollback_en && ready_in && (rob_idx == rollback_idx);

  // low chunk of multiplier times the full multiplicand, truncated
  assign partial      = mplier_in[CHUNK-1:0] * mcand_in;
  assign next_product = product_in + partial;

  // upstream may move when its slot is empty, we take it, or it dies
  assign advance_prev = !ready_in || advance || squash;

  always_ff @(posedge clock or negedge rst_n) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else if (advance) begin
      // squashed entries enter as a bubble
      done <= ready_in && !squash;
    end
  end

  // payload only moves with advance
  always_ff @(posedge clock) begin
    if (advance) begin
      product_out <= next_product;
      mplier_out  <= mplier_in >> CHUNK;
      mcand_out   <= mcand_in << CHUNK;
      t_idx_out   <= t_idx;
      rob_idx_out <= rob_idx;
    end
  end

endmodule

`default_nettype wire

/* run_sim.sh */
#!/bin/sh
# build and run the execute cluster testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module tb_exec_unit \
  -Mdir obj_dir -o tb_exec_unit
status=$?
if [ "$status" -ne 0 ]; then
  echo "verilator build returned status $status"
  exit "$status"
fi

./obj_dir/tb_exec_unit
status=$?
if [ "$status" -ne 0 ]; then
  echo "run ended with status $status"
  exit "$status"
fi

exit 0

/* sources.f */
+incdir+rtl
rtl/exec_pkg.sv
rtl/alu.sv
rtl/mult_stage.sv
rtl/mult.sv
rtl/br_unit.sv
rtl/exec_unit.sv
verif/exec_ref_pkg.sv
verif/tb_exec_unit.sv

/* verif/exec_ref_pkg.sv */
`default_nettype none

`include "exec_params.svh"

package exec_ref_pkg;
  import exec_pkg::*;

  localparam int SH_W = $clog2(`XLEN);

  // 0 or 1 in bit 0, as the compares return it
  function automatic data_t bool_word(input logic flag);
    data_t w;
    w    = '0;
    w[0] = flag;
    return w;
  endfunction

  // second operand as picked by the packet, literal zero-extended
  function automatic data_t operand_b_ref(input opb_sel_e sel, input data_t regb,
                                          input imm_t imm);
    data_t lit;
    lit            = '0;
    lit[`IMM_W-1:0] = imm;
    return (sel == opb_is_imm) ? lit : regb;
  endfunction

  function automatic data_t alu_ref(input alu_func_e func, input data_t a, input data_t b);
    logic [SH_W-1:0]         sh;
    logic signed [`XLEN-1:0] sa;
    logic signed [`XLEN-1:0] sb;
    sh = b[SH_W-1:0];
    sa = a;
    sb = b;
    case (func)
      alu_addq:   return a + b;
      alu_subq:   return a - b;
      alu_and:    return a & b;
      alu_bic:    return a & ~b;
      alu_bis:    return a | b;
      alu_ornot:  return a | ~b;
      alu_xor:    return a ^ b;
      alu_eqv:    return ~(a ^ b);
      alu_srl:    return a >> sh;
      alu_sll:    return a << sh;
      // arithmetic shift straight from the signed operator
      alu_sra:    return sa >>> sh;
      alu_cmpult: return bool_word(a < b);
      alu_cmpeq:  return bool_word(a == b);
      alu_cmpule: return bool_word(a <= b);
      alu_cmplt:  return bool_word(sa < sb);
      default:    return bool_word(sa <= sb);
    endcase
  endfunction

  // low half of the full product
  function automatic data_t product_ref(input data_t a, input data_t b);
    data_t p;
    p = a * b;
    return p;
  endfunction

  // all eight conditions spelled out on the first operand
  function automatic logic branch_taken_ref(input br_cond_e cond, input logic is_cond,
                                            input logic is_uncond, input data_t a);
    logic neg;
    logic zero;
    logic holds;
    neg  = a[`XLEN-1];
    zero = (a == '0);
    case (cond)
      br_lbc:  holds = !a[0];
      br_lbs:  holds = a[0];
      br_eq:   holds = zero;
      br_ne:   holds = !zero;
      br_lt:   holds = neg;
      br_ge:   holds = !neg;
      br_le:   holds = neg || zero;
      default: holds = !neg && !zero;
    endcase
    return is_uncond || (is_cond && holds);
  endfunction

  // npc plus four times the signed word displacement
  function automatic data_t branch_target_ref(input data_t npc, input br_disp_t disp);
    logic signed [`XLEN-1:0] off;
    off = `XLEN'($signed(disp));
    return npc + data_t'(off * 4);
  endfunction

endpackage

`default_nettype wire

/* verif/tb_exec_unit.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exec_params.svh"

module tb_exec_unit import exec_pkg::*, exec_ref_pkg::*; ();

  localparam int N       = `NUM_MULT_STAGE;
  localparam int TIMEOUT = 50;

  // one expected product, kept in issue order
  typedef struct packed {
    data_t       value;
    pr_idx_t     t_idx;
    rob_idx_t    rob_idx;
    logic [31:0] accept_edge;
  } mult_exp_t;

  logic        clock;
  logic        rst_n;
  fu_packet_t  alu_packet;
  fu_packet_t  mult_packet;
  fu_packet_t  br_packet;
  logic        alu_cdb_valid;
  logic        mult_cdb_valid;
  logic        rollback_en;
  rob_idx_t    rollback_idx;
  fu_result_t  alu_result;
  fu_result_t  mult_result;
  fu_result_t  br_result;
  logic        alu_free;
  logic        mult_free;
  logic        take_branch;
  integer      seed;
  logic [31:0] edge_count = '0;
  int          consumed = 0;
  logic        check_latency;
  mult_exp_t   exp_q [$];

  exec_unit uut (
    .clock          (clock),
    .rst_n          (rst_n),
    .alu_packet     (alu_packet),
    .mult_packet    (mult_packet),
    .br_packet      (br_packet),
    .alu_cdb_valid  (alu_cdb_valid),
    .mult_cdb_valid (mult_cdb_valid),
    .rollback_en    (rollback_en),
    .rollback_idx   (rollback_idx),
    .alu_result     (alu_result),
    .mult_result    (mult_result),
    .br_result      (br_result),
    .alu_free       (alu_free),
    .mult_free      (mult_free),
    .take_branch    (take_branch)
  );

  initial clock = 1'b0;
  always #5 clock = ~clock;

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_value(input string name, input logic [63:0] got,
                             input logic [63:0] exp);
    assert (got === exp)
      else fail_now($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
  endtask

  // done and both tags of a combinational unit
  task automatic check_tags(input string unit, input fu_result_t r, input fu_packet_t p);
    check_value({unit, ".done"}, 64'(r.done), 64'(1'b1));
    check_value({unit, ".t_idx"}, 64'(r.t_idx), 64'(p.t_idx));
    check_value({unit, ".rob_idx"}, 64'(r.rob_idx), 64'(p.rob_idx));
  endtask

  function automatic data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // present one product at a falling edge, optionally with a rollback
  task automatic issue_mult(input data_t a, input data_t b, input rob_idx_t rob,
                            input logic kill, input rob_idx_t kill_idx, output int waits);
    waits = 0;
    @(negedge clock);
    mult_packet.ready    = 1'b1;
    mult_packet.t1_value = a;
    mult_packet.t2_value = b;
    mult_packet.opb_sel  = opb_sel_e'(1'($random(seed)));
    mult_packet.imm      = imm_t'($random(seed));
    mult_packet.t_idx    = pr_idx_t'($random(seed));
    mult_packet.rob_idx  = rob;
    rollback_en          = kill;
    rollback_idx         = kill_idx;
    @(posedge clock);
    // packet stays until the multiplier is free
    while (!mult_free) begin
      waits++;
      if (waits > TIMEOUT) fail_now("timeout waiting for the multiplier to take a packet");
      @(posedge clock);
    end
  endtask

  task automatic drain_mult();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      waited++;
      if (waited > TIMEOUT) fail_now("timeout waiting for multiplier results");
      @(negedge clock);
    end
  endtask

  // stalled output must hold still
  assert property (@(posedge clock) disable iff (!rst_n)
    (mult_result.done && !mult_cdb_valid && !rollback_en) |=> $stable(mult_result))
    else fail_now("multiplier result changed while the bus held it off");

  // squashed ALU work is dropped and frees the unit
  assert property (@(posedge clock) disable iff (!rst_n)
    (alu_packet.ready && rollback_en && alu_packet.rob_idx == rollback_idx)
      |-> (!alu_result.done && alu_free))
    else fail_now("ALU kept an op whose reorder buffer entry was rolled back");

  // multiplier scoreboard, every rising edge
  always @(posedge clock) begin : mult_monitor
    mult_exp_t head;
    mult_exp_t fresh;
    int        i;
    if (rst_n) begin
      if (mult_result.done && mult_cdb_valid) begin
        assert (exp_q.size() != 0)
          else fail_now("multiplier returned a product that was never issued");
        head = exp_q.pop_front();
        check_value("mult_result.result", mult_result.result, head.value);
        check_value("mult_result.t_idx", 64'(mult_result.t_idx), 64'(head.t_idx));
        check_value("mult_result.rob_idx", 64'(mult_result.rob_idx), 64'(head.rob_idx));
        if (check_latency) begin
          check_value("mult_result latency", 64'(edge_count - head.accept_edge), 64'(N - 1));
        end
        consumed++;
      end
      // rolled back products never reach the bus
      if (rollback_en) begin
        for (i = exp_q.size() - 1; i >= 0; i--) begin
          if (exp_q[i].rob_idx == rollback_idx) exp_q.delete(i);
        end
      end
      if (mult_packet.ready && mult_free &&
          !(rollback_en && mult_packet.rob_idx == rollback_idx)) begin
        fresh.value       = product_ref(mult_packet.t1_value, operand_b_ref(
                              mult_packet.opb_sel, mult_packet.t2_value, mult_packet.imm));
        fresh.t_idx       = mult_packet.t_idx;
        fresh.rob_idx     = mult_packet.rob_idx;
        fresh.accept_edge = edge_count;
        exp_q.push_back(fresh);
      end
    end
    edge_count = edge_count + 1'b1;
  end

  initial begin
    int         f;
    int         s;
    int         rep;
    int         kind;
    int         base;
    int         waits;
    fu_packet_t p;
    seed           = 32'hfa02;
    rst_n          = 1'b0;
    alu_packet     = '0;
    mult_packet    = '0;
    br_packet      = '0;
    alu_cdb_valid  = 1'b0;
    mult_cdb_valid = 1'b0;
    rollback_en    = 1'b0;
    rollback_idx   = '0;
    check_latency  = 1'b0;
    repeat (10) @(posedge clock);
    @(negedge clock);
    rst_n = 1'b1;
    @(posedge clock);
    check_value("mult_free", 64'(mult_free), 64'(1'b1));
    check_value("mult_result.done", 64'(mult_result.done), 64'(1'b0));
    check_value("alu_result.done", 64'(alu_result.done), 64'(1'b0));

    // every alu op, both operand b sources
    alu_cdb_valid = 1'b1;
    for (f = 0; f < 16; f++) begin
      for (s = 0; s < 2; s++) begin
        for (rep = 0; rep < 4; rep++) begin
          @(negedge clock);
          p          = '0;
          p.ready    = 1'b1;
          p.func     = alu_func_e'(f[3:0]);
          p.opb_sel  = opb_sel_e'(s[0]);
          p.t1_value = rand_word();
          p.t2_value = (rep == 0) ? p.t1_value : rand_word();
          p.imm      = imm_t'($random(seed));
          p.t_idx    = pr_idx_t'($random(seed));
          p.rob_idx  = rob_idx_t'($random(seed));
          // equal operands for the eq and le cases
          if (rep == 0 && s == 1) p.t1_value = operand_b_ref(opb_is_imm, '0, p.imm);
          alu_packet = p;
          @(posedge clock);
          check_value("alu_result.result", alu_result.result, alu_ref(p.func, p.t1_value,
                      operand_b_ref(p.opb_sel, p.t2_value, p.imm)));
          check_tags("alu_result", alu_result, p);
          check_value("alu_free", 64'(alu_free), 64'(1'b1));
        end
      end
    end

    // rollback on the alu, matching then other index
    @(negedge clock);
    alu_cdb_valid      = 1'b0;
    alu_packet.rob_idx = rob_idx_t'(9);
    rollback_en        = 1'b1;
    rollback_idx       = rob_idx_t'(9);
    @(posedge clock);
    check_value("alu_result.done", 64'(alu_result.done), 64'(1'b0));
    check_value("alu_free", 64'(alu_free), 64'(1'b1));
    @(negedge clock);
    rollback_idx = rob_idx_t'(10);
    @(posedge clock);
    check_value("alu_result.done", 64'(alu_result.done), 64'(1'b1));
    check_value("alu_free", 64'(alu_free), 64'(1'b0));
    @(negedge clock);
    rollback_en = 1'b0;
    alu_packet  = '0;

    // back to back products, bus always granting
    mult_cdb_valid = 1'b1;
    check_latency  = 1'b1;
    for (rep = 0; rep < 12; rep++) begin
      issue_mult(rand_word(), rand_word(), rob_idx_t'(rep), 1'b0, '0, waits);
      check_value("mult_free stall cycles", 64'(waits), 64'(0));
    end
    @(negedge clock);
    mult_packet.ready = 1'b0;
    drain_mult();

    // bus held off until the chain fills
    mult_cdb_valid = 1'b0;
    check_latency  = 1'b0;
    base           = consumed;
    for (rep = 0; rep < N - 1; rep++) begin
      issue_mult(rand_word(), rand_word(), rob_idx_t'(rep), 1'b0, '0, waits);
    end
    @(negedge clock);
    mult_packet.rob_idx  = rob_idx_t'(7);
    mult_packet.t1_value = rand_word();
    repeat (5) begin
      @(posedge clock);
      assert (!mult_free) else fail_now("mult_free stayed high with the pipeline full");
      assert (mult_result.done) else fail_now("stalled multiplier dropped its done");
    end
    @(negedge clock);
    mult_cdb_valid = 1'b1;
    @(posedge clock);
    check_value("mult_free", 64'(mult_free), 64'(1'b1));
    @(negedge clock);
    mult_packet.ready = 1'b0;
    drain_mult();
    check_value("mult products after stall", 64'(consumed - base), 64'(N));

    // kill rob 2 while it sits in the pipeline
    check_latency = 1'b1;
    base          = consumed;
    for (rep = 0; rep < 6; rep++) begin
      issue_mult(rand_word(), rand_word(), rob_idx_t'(rep), rep == 4, rob_idx_t'(2), waits);
    end
    @(negedge clock);
    mult_packet.ready = 1'b0;
    rollback_en       = 1'b0;
    drain_mult();
    check_value("mult products after squash", 64'(consumed - base), 64'(5));

    // every condition, conditional, unconditional and neither
    for (f = 0; f < 8; f++) begin
      for (kind = 0; kind < 3; kind++) begin
        for (rep = 0; rep < 4; rep++) begin
          @(negedge clock);
          p               = '0;
          p.ready         = 1'b1;
          p.br_cond       = br_cond_e'(f[2:0]);
          p.cond_branch   = (kind == 0);
          p.uncond_branch = (kind == 1);
          p.t1_value      = (rep == 0) ? '0 : rand_word();
          p.npc           = rand_word();
          p.br_disp       = br_disp_t'($random(seed));
          p.t_idx         = pr_idx_t'($random(seed));
          p.rob_idx       = rob_idx_t'($random(seed));
          br_packet       = p;
          @(posedge clock);
          check_value("take_branch", 64'(take_branch), 64'(branch_taken_ref(p.br_cond,
                      p.cond_branch, p.uncond_branch, p.t1_value)));
          check_value("br_result.result", br_result.result,
                      branch_target_ref(p.npc, p.br_disp));
          check_tags("br_result", br_result, p);
        end
      end
    end

    $display("Simulation passed");
    $finish;
  end

endmodule

`default_nettype wire
